// ==== Makefile ====
TOP = tb_usb_bulk_loopback

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove obj_dir and sim.log"

test:
	verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) 2>&1 | tee sim.log
	@if grep -q "Errors found" sim.log || ! grep -q "No errors" sim.log; then \
		echo "TEST FAILED"; exit 1; \
	else \
		echo "TEST PASSED"; \
	fi

clean:
	rm -rf obj_dir sim.log

// ==== bulk_out_rx/bulk_out_rx.sv ====
`timescale 1ns/1ps
`include "loop_cfg.svh"

module bulk_out_rx
  import usb_types_pkg::*;
  import fifo_types_pkg::*;
(
  input  logic       clock,
  input  logic       usb_reset,
  input  logic       configured_i,
  input  logic       out_valid_i,
  input  byte_t      out_data_i,
  input  logic       out_last_i,
  output logic       out_credit_o,
  output logic       push_o,
  output fifo_word_t push_word_o,
  input  logic       fifo_credit_i,
  output logic       pkt_err_o
);

  localparam int SABITS = $clog2(`OUT_CREDITS);
  localparam pkt_len_t LAST_IDX = pkt_len_t'(`MAX_PKT_BYTES - 1);

  // Staging queue, one slot per host credit
  byte_t stg_data [`OUT_CREDITS];
  logic  stg_last [`OUT_CREDITS];
  logic  stg_drop [`OUT_CREDITS];

  logic [SABITS-1:0] wr_ptr;
  logic [SABITS-1:0] rd_ptr;
  logic [SABITS:0]   stg_cnt;

  credit_t  fifo_cred;
  pkt_len_t pkt_cnt;
  logic     trunc_q;

  logic head_valid;
  logic head_last;
  logic discard;
  logic force_last;
  logic leave;

  assign head_valid = stg_cnt != '0;
  assign head_last  = stg_last[rd_ptr];
  // Unconfigured bytes and the tail of an oversize packet go nowhere
  assign discard    = stg_drop[rd_ptr] || trunc_q;
  assign force_last = pkt_cnt == LAST_IDX;

  assign push_o      = head_valid && !discard && fifo_cred != '0;
  assign leave       = head_valid && (discard || fifo_cred != '0);
  assign push_word_o = {head_last || force_last, stg_data[rd_ptr]};

  // Configuration is sampled as the byte arrives
  always_ff @(posedge clock) begin
    if (out_valid_i) begin
      stg_data[wr_ptr] <= out_data_i;
      stg_last[wr_ptr] <= out_last_i;
      stg_drop[wr_ptr] <= !configured_i;
    end
  end

  always_ff @(posedge clock) begin
    if (usb_reset) begin
      wr_ptr       <= '0;
      rd_ptr       <= '0;
      stg_cnt      <= '0;
      fifo_cred    <= credit_t'(`LOOP_FIFO_DEPTH);
      out_credit_o <= 1'b0;
      pkt_cnt      <= '0;
      trunc_q      <= 1'b0;
      pkt_err_o    <= 1'b0;
    end else begin
      out_credit_o <= leave;
      if (out_valid_i) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (leave) begin
        rd_ptr <= rd_ptr + 1'b1;
      end

      case ({out_valid_i, leave})
        2'b10:   stg_cnt <= stg_cnt + 1'b1;
        2'b01:   stg_cnt <= stg_cnt - 1'b1;
        default: stg_cnt <= stg_cnt;
      endcase

      case ({push_o, fifo_credit_i})
        2'b10:   fifo_cred <= fifo_cred - 1'b1;
        2'b01:   fifo_cred <= fifo_cred + 1'b1;
        default: fifo_cred <= fifo_cred;
      endcase

      if (push_o) begin
        if (head_last || force_last) begin
          pkt_cnt <= '0;
        end else begin
          pkt_cnt <= pkt_cnt + 1'b1;
        end
        // Exactly 512 bytes is legal, only a longer packet is an error
        if (force_last && !head_last) begin
          trunc_q   <= 1'b1;
          pkt_err_o <= 1'b1;
        end
      end else if (leave && head_last) begin
        pkt_cnt <= '0;
        trunc_q <= 1'b0;
      end
    end
  end

  // Host may only send while it holds a credit for a free slot
  assert property (@(posedge clock) disable iff (usb_reset)
    out_valid_i |-> stg_cnt < `OUT_CREDITS)
    else $error("bulk_out_rx: OUT byte with staging full");

endmodule

// ==== common/fifo_types_pkg.sv ====
`include "loop_cfg.svh"

package fifo_types_pkg;

  // Last flag in bit 8, byte below it
  typedef logic [8:0] fifo_word_t;

  // Fill level, one bit wider than the address so a full RAM fits
  typedef logic [`LOOP_FIFO_ABITS:0] level_t;

  // Credit counter, holds up to the full FIFO depth
  typedef logic [`LOOP_FIFO_ABITS:0] credit_t;

endpackage

// ==== common/loop_cfg.svh ====
`ifndef LOOP_CFG_SVH
`define LOOP_CFG_SVH

// Loop-back RAM address width and depth
`define LOOP_FIFO_ABITS 11
`define LOOP_FIFO_DEPTH (1 << `LOOP_FIFO_ABITS)

// High-speed bulk max packet size
`define MAX_PKT_BYTES 512

// Host side credits, also the producer staging depth
`define OUT_CREDITS 4

// Credits toward the IN sink
`define IN_CREDITS 4

// Endpoint readiness thresholds on the FIFO level
`define IN_READY_LEVEL 4
`define OUT_READY_LEVEL 1024

`endif

// ==== common/usb_types_pkg.sv ====
package usb_types_pkg;

  // One byte on the bulk endpoints
  typedef logic [7:0] byte_t;

  // Byte count within one packet, covers the 512-byte limit
  typedef logic [9:0] pkt_len_t;

endpackage

// ==== flist.f ====
+incdir+common
common/usb_types_pkg.sv
common/fifo_types_pkg.sv
bulk_out_rx/bulk_out_rx.sv
loopback_fifo/loopback_fifo.sv
verilog/bulk_in_tx.sv
verilog/usb_bulk_loopback.sv
sim/tb_usb_bulk_loopback.sv

// ==== loopback_fifo/loopback_fifo.sv ====
`timescale 1ns/1ps
`include "loop_cfg.svh"

module loopback_fifo
  import fifo_types_pkg::*;
(
  input  logic       clock,
  input  logic       usb_reset,
  input  logic       configured_i,
  input  logic       push_i,
  input  fifo_word_t push_word_i,
  output logic       credit_o,
  input  logic       pop_i,
  output logic       rd_valid_o,
  output fifo_word_t rd_word_o,
  output logic       not_empty_o,
  output level_t     level_o,
  output logic       blk_in_ready_o,
  output logic       blk_out_ready_o
);

  fifo_word_t mem [`LOOP_FIFO_DEPTH];

  logic [`LOOP_FIFO_ABITS-1:0] wr_ptr;
  logic [`LOOP_FIFO_ABITS-1:0] rd_ptr;

  level_t level_q;
  level_t level_avail;

  // Words written before this edge, minus the one being read now
  assign level_avail = level_q - level_t'(pop_i);
  assign level_o     = level_q;

  always_ff @(posedge clock) begin
    if (push_i) begin
      mem[wr_ptr] <= push_word_i;
    end
    if (pop_i) begin
      rd_word_o <= mem[rd_ptr];
    end
  end

  always_ff @(posedge clock) begin
    if (usb_reset) begin
      wr_ptr          <= '0;
      rd_ptr          <= '0;
      level_q         <= '0;
      rd_valid_o      <= 1'b0;
      credit_o        <= 1'b0;
      not_empty_o     <= 1'b0;
      blk_in_ready_o  <= 1'b0;
      blk_out_ready_o <= 1'b0;
    end else begin
      rd_valid_o  <= pop_i;
      credit_o    <= pop_i;
      // Lags a push by a cycle but drops on the last pop
      not_empty_o <= level_avail != '0;

      if (push_i) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop_i) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      level_q <= level_avail + level_t'(push_i);

      // Endpoint status for the USB core
      blk_in_ready_o  <= configured_i && level_q > level_t'(`IN_READY_LEVEL);
      blk_out_ready_o <= configured_i && level_q < level_t'(`OUT_READY_LEVEL);
    end
  end

  // Producer credits keep it from overrunning the RAM
  assert property (@(posedge clock) disable iff (usb_reset)
    push_i |-> level_q < `LOOP_FIFO_DEPTH)
    else $error("loopback_fifo: push while full");

  // Consumer pops only on not_empty_o
  assert property (@(posedge clock) disable iff (usb_reset)
    pop_i |-> level_q != '0)
    else $error("loopback_fifo: pop while empty");

endmodule

// ==== sim/tb_usb_bulk_loopback.sv ====
`timescale 1ns/1ps
`include "loop_cfg.svh"

module tb_usb_bulk_loopback
  import usb_types_pkg::*;
  import fifo_types_pkg::*;
();

  logic clock, usb_reset, configured_i, out_valid_i, out_last_i, in_credit_i;
  logic out_credit_o, in_valid_o, in_last_o, blk_in_ready_o, blk_out_ready_o, pkt_err_o;
  byte_t out_data_i, in_data_o;
  level_t level_o;
  logic [15:0] in_pkt_count_o;

  // Reference state, last flag in bit 8 of each expected word
  logic [8:0] exp_q[$];
  logic [8:0] exp_w;
  int exp_len = 0;
  int exp_pkts = 0;
  logic exp_trunc = 1'b0;
  logic exp_err = 1'b0;

  // OUT bytes sent and credits back, IN bytes seen and credits granted
  int sent_cnt = 0;
  int ret_cnt = 0;
  int rx_cnt = 0;
  int granted = 0;
  int gap = 0;
  int err_cnt = 0;
  int chk_cnt = 0;
  int hold;
  logic sink_en = 1'b1;
  logic send_busy = 1'b0;
  logic [31:0] rnd = 32'h8fce_760f;
  logic [31:0] sink_rnd = 32'h8fce_760f;

  usb_bulk_loopback usb_bulk_loopback_inst (.*);

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  // Drop while unconfigured, cut at the packet limit, skip to the real last
  function automatic void model_byte(input byte_t d, input logic last, input logic cfg);
    logic cut;
    cut = exp_len == `MAX_PKT_BYTES - 1;
    if (cfg && !exp_trunc) begin
      exp_q.push_back({last || cut, d});
      exp_len = (last || cut) ? 0 : exp_len + 1;
      exp_pkts += (last || cut) ? 1 : 0;
      exp_trunc = cut && !last;
      exp_err = exp_err || (cut && !last);
    end else if (cfg && last) begin
      exp_trunc = 1'b0;
    end
  endfunction

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("ERROR %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic timeout_fail(input string what);
    $display("Timed out waiting for %s", what);
    $display("checks: %0d, errors: %0d", chk_cnt, err_cnt + 1);
    $display("Errors found");
    $finish;
  endtask

  task automatic settle(input int cycles);
    repeat (cycles) @(posedge clock);
    #1;
  endtask

  // Host side, one byte per held OUT credit
  task automatic send_byte(input byte_t d, input logic last);
    int n;
    n = 0;
    while (sent_cnt - ret_cnt >= `OUT_CREDITS) begin
      settle(1);
      n++;
      if (n > 5000) timeout_fail("an OUT credit");
    end
    model_byte(d, last, configured_i);
    sent_cnt++;
    out_valid_i = 1'b1;
    out_data_i = d;
    out_last_i = last;
    settle(1);
    out_valid_i = 1'b0;
  endtask

  task automatic send_packet(input int len);
    for (int i = 0; i < len; i++) begin
      rnd = xorshift(rnd);
      send_byte(rnd[7:0], i == len - 1);
    end
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (send_busy || ret_cnt != sent_cnt || exp_q.size() != 0 || granted != rx_cnt) begin
      settle(1);
      n++;
      if (n > 20000) timeout_fail("the loopback path to drain");
    end
  endtask

  task automatic wait_level_above(input int lvl);
    int n;
    n = 0;
    while (level_o <= lvl) begin
      settle(1);
      n++;
      if (n > 10000) timeout_fail("the FIFO level to rise");
    end
  endtask

  // IN sink returns one credit per received byte after a random gap
  initial begin
    forever begin
      settle(1);
      in_credit_i = 1'b0;
      if (sink_en && granted < rx_cnt) begin
        if (gap == 0) begin
          in_credit_i = 1'b1;
          granted++;
          sink_rnd = xorshift(sink_rnd);
          gap = int'(sink_rnd[1:0]);
        end else begin
          gap--;
        end
      end
    end
  end

  // Each IN byte against the head of the reference queue
  always @(posedge clock) begin
    if (out_credit_o) ret_cnt++;
    if (!usb_reset && in_valid_o) begin
      rx_cnt++;
      if (rx_cnt > `IN_CREDITS + granted) begin
        err_cnt++;
        $display("IN byte %0d was sent without an IN credit", rx_cnt);
      end
      if (exp_q.size() == 0) begin
        err_cnt++;
        $display("Unexpected IN byte %h with nothing left to receive", in_data_o);
      end else begin
        exp_w = exp_q.pop_front();
        compare("in_data_o", in_data_o, exp_w[7:0]);
        compare("in_last_o", in_last_o, exp_w[8]);
      end
    end
  end

  initial begin
    usb_reset = 1'b1;
    configured_i = 1'b0;
    out_valid_i = 1'b0;
    out_data_i = '0;
    out_last_i = 1'b0;
    in_credit_i = 1'b0;
    settle(5);
    compare("reset outputs",
            {out_credit_o, in_valid_o, blk_in_ready_o, blk_out_ready_o, pkt_err_o}, 0);
    usb_reset = 1'b0;
    configured_i = 1'b1;
    for (int p = 0; p < 20; p++) begin
      rnd = xorshift(rnd);
      send_packet(1 + int'(rnd % 100));
    end
    wait_drain();
    compare("in_pkt_count_o", in_pkt_count_o, exp_pkts);

    // Unconfigured traffic vanishes but its credits come back
    configured_i = 1'b0;
    send_packet(40);
    send_packet(40);
    wait_drain();
    compare("in_pkt_count_o", in_pkt_count_o, exp_pkts);
    configured_i = 1'b1;

    send_packet(600);
    send_packet(10);
    wait_drain();
    compare("in_pkt_count_o", in_pkt_count_o, exp_pkts);
    compare("pkt_err_o", pkt_err_o, exp_err);

    // Stalled sink, path fills up to the host
    settle(2);
    compare("blk_in_ready_o", blk_in_ready_o, 0);
    compare("blk_out_ready_o", blk_out_ready_o, 1);
    sink_en = 1'b0;
    send_busy = 1'b1;
    fork
      begin
        for (int p = 0; p < 22; p++) begin
          send_packet(100);
        end
        send_busy = 1'b0;
      end
    join_none
    wait_level_above(`IN_READY_LEVEL);
    settle(2);
    compare("blk_in_ready_o", blk_in_ready_o, 1);
    wait_level_above(`OUT_READY_LEVEL);
    settle(2);
    compare("blk_out_ready_o", blk_out_ready_o, 0);
    wait_level_above(`LOOP_FIFO_DEPTH - 1);
    settle(4);
    hold = ret_cnt;
    settle(50);
    compare("out_credit_o pulses", ret_cnt, hold);
    compare("OUT credits held", sent_cnt - ret_cnt, `OUT_CREDITS);
    sink_en = 1'b1;
    wait_drain();
    settle(2);
    compare("level_o", level_o, 0);
    compare("blk_in_ready_o", blk_in_ready_o, 0);
    compare("blk_out_ready_o", blk_out_ready_o, 1);
    compare("in_pkt_count_o", in_pkt_count_o, exp_pkts);
    compare("pkt_err_o", pkt_err_o, exp_err);

    $display("checks: %0d, errors: %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// ==== verilog/bulk_in_tx.sv ====
`timescale 1ns/1ps
`include "loop_cfg.svh"

module bulk_in_tx
  import usb_types_pkg::*;
  import fifo_types_pkg::*;
(
  input  logic        clock,
  input  logic        usb_reset,
  output logic        pop_o,
  input  logic        not_empty_i,
  input  logic        rd_valid_i,
  input  fifo_word_t  rd_word_i,
  output logic        in_valid_o,
  output byte_t       in_data_o,
  output logic        in_last_o,
  input  logic        in_credit_i,
  output logic [15:0] in_pkt_count_o
);

  // Credit is taken at the pop, so reads in flight are covered
  credit_t in_cred;

  assign pop_o = not_empty_i && in_cred != '0;

  always_ff @(posedge clock) begin
    if (usb_reset) begin
      in_cred        <= credit_t'(`IN_CREDITS);
      in_valid_o     <= 1'b0;
      in_pkt_count_o <= '0;
    end else begin
      in_valid_o <= rd_valid_i;

      case ({pop_o, in_credit_i})
        2'b10:   in_cred <= in_cred - 1'b1;
        2'b01:   in_cred <= in_cred + 1'b1;
        default: in_cred <= in_cred;
      endcase

      // Packet done when its last byte goes out
      if (rd_valid_i && rd_word_i[8]) begin
        in_pkt_count_o <= in_pkt_count_o + 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (rd_valid_i) begin
      in_data_o <= rd_word_i[7:0];
      in_last_o <= rd_word_i[8];
    end
  end

  // Sink never hands back more credits than were spent
  assert property (@(posedge clock) disable iff (usb_reset)
    in_cred <= `IN_CREDITS)
    else $error("bulk_in_tx: IN credit overflow");

endmodule

// ==== verilog/usb_bulk_loopback.sv ====
`timescale 1ns/1ps

module usb_bulk_loopback
  import usb_types_pkg::*;
  import fifo_types_pkg::*;
(
  input  logic        clock,
  input  logic        usb_reset,
  input  logic        configured_i,
  input  logic        out_valid_i,
  input  byte_t       out_data_i,
  input  logic        out_last_i,
  output logic        out_credit_o,
  output logic        in_valid_o,
  output byte_t       in_data_o,
  output logic        in_last_o,
  input  logic        in_credit_i,
  output level_t      level_o,
  output logic        blk_in_ready_o,
  output logic        blk_out_ready_o,
  output logic        pkt_err_o,
  output logic [15:0] in_pkt_count_o
);

  // Producer to buffer
  logic       push;
  fifo_word_t push_word;
  logic       fifo_credit;

  // Buffer to consumer
  logic       pop;
  logic       rd_valid;
  fifo_word_t rd_word;
  logic       not_empty;

  bulk_out_rx bulk_out_rx_inst (
    .clock        (clock),
    .usb_reset    (usb_reset),
    .configured_i (configured_i),
    .out_valid_i  (out_valid_i),
    .out_data_i   (out_data_i),
    .out_last_i   (out_last_i),
    .out_credit_o (out_credit_o),
    .push_o       (push),
    .push_word_o  (push_word),
    .fifo_credit_i(fifo_credit),
    .pkt_err_o    (pkt_err_o)
  );

  loopback_fifo loopback_fifo_inst (
    .clock          (clock),
    .usb_reset      (usb_reset),
    .configured_i   (configured_i),
    .push_i         (push),
    .push_word_i    (push_word),
    .credit_o       (fifo_credit),
    .pop_i          (pop),
    .rd_valid_o     (rd_valid),
    .rd_word_o      (rd_word),
    .not_empty_o    (not_empty),
    .level_o        (level_o),
    .blk_in_ready_o (blk_in_ready_o),
    .blk_out_ready_o(blk_out_ready_o)
  );

  bulk_in_tx bulk_in_tx_inst (
    .clock         (clock),
    .usb_reset     (usb_reset),
    .pop_o         (pop),
    .not_empty_i   (not_empty),
    .rd_valid_i    (rd_valid),
    .rd_word_i     (rd_word),
    .in_valid_o    (in_valid_o),
    .in_data_o     (in_data_o),
    .in_last_o     (in_last_o),
    .in_credit_i   (in_credit_i),
    .in_pkt_count_o(in_pkt_count_o)
  );

endmodule
